/* display_pkg.sv */
/* display timing package
   640x480 raster constants and the screen coordinate type */
package display_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate, fits 0..799

    // horizontal timing in pixels
    localparam coord_t h_res   = 10'd640;  // visible width
    localparam coord_t h_fp    = 10'd16;   // front porch
    localparam coord_t h_sync  = 10'd96;   // sync pulse
    localparam coord_t h_bp    = 10'd48;   // back porch
    localparam coord_t h_total = 10'd800;  // full line incl. blanking

    // vertical timing in lines
    localparam coord_t v_res   = 10'd480;  // visible height
    localparam coord_t v_fp    = 10'd10;   // front porch
    localparam coord_t v_sync  = 10'd2;    // sync pulse
    localparam coord_t v_bp    = 10'd33;   // back porch
    localparam coord_t v_total = 10'd525;  // full frame incl. blanking

    // sync windows, first and last position with sync asserted
    localparam coord_t h_sync_beg = h_res + h_fp;             // 656
    localparam coord_t h_sync_end = h_res + h_fp + h_sync - 1; // 751
    localparam coord_t v_sync_beg = v_res + v_fp;             // 490
    localparam coord_t v_sync_end = v_res + v_fp + v_sync - 1; // 491

    // last position of a line and of a frame
    localparam coord_t h_last = h_total - 1;
    localparam coord_t v_last = v_total - 1;

    // both syncs are active low at 640x480
    localparam logic sync_active = 1'b0;

endpackage

/* fb_pkg.sv */
/* framebuffer package
   image size, address and colour types for the 1-bit framebuffer */
package fb_pkg;

    typedef logic [14:0] fb_addr_t;  // pixel address, 0..19199
    typedef logic        fb_colr_t;  // one colour bit per pixel
    typedef logic [3:0]  rgb_t;      // one vga colour channel

    // image size
    localparam fb_addr_t fb_width  = 15'd160;
    localparam fb_addr_t fb_height = 15'd120;
    localparam fb_addr_t fb_pixels = fb_width * fb_height;  // 19200

    // channel levels for set and clear pixels
    localparam rgb_t rgb_on  = '1;  // full white
    localparam rgb_t rgb_off = '0;  // black

endpackage

/* display_if.sv */
/* raster bus
   position, syncs and blanking from the timing generator to the scanout */
interface display_if;

    display_pkg::coord_t sx;   // horizontal position
    display_pkg::coord_t sy;   // vertical position
    logic hsync;               // horizontal sync, active low
    logic vsync;               // vertical sync, active low
    logic de;                  // inside the 640x480 visible area
    logic frame_end;           // one cycle at (799, 524)

    // timing generator side
    modport src (
        output sx, sy, hsync, vsync, de, frame_end
    );

    // scanout side
    modport dst (
        input sx, sy, hsync, vsync, de, frame_end
    );

endinterface

/* display_timings.sv */
/* display timing generator
   800x525 raster counters with sync, data enable and end of frame decode */
module display_timings (
    input  logic   clk_pix,
    input  logic   rst,
    display_if.src disp
);

    display_pkg::coord_t sx;
    display_pkg::coord_t sy;
    logic line_end;  // last pixel of the current line

    assign line_end = (sx == display_pkg::h_last);

    // position counters, one pixel per clock
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;  // first cycle out of reset is (0,0)
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            if (sy == display_pkg::v_last) begin
                sy <= '0;  // wrap to top of next frame
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync and blanking decode straight from the counters
    always_comb begin
        disp.sx = sx;
        disp.sy = sy;
        if (sx >= display_pkg::h_sync_beg && sx <= display_pkg::h_sync_end) begin
            disp.hsync = display_pkg::sync_active;
        end else begin
            disp.hsync = ~display_pkg::sync_active;
        end
        if (sy >= display_pkg::v_sync_beg && sy <= display_pkg::v_sync_end) begin
            disp.vsync = display_pkg::sync_active;
        end else begin
            disp.vsync = ~display_pkg::sync_active;
        end
        disp.de        = (sx < display_pkg::h_res) && (sy < display_pkg::v_res);
        disp.frame_end = line_end && (sy == display_pkg::v_last);
    end

    // counters never leave the raster
    assert property (@(posedge clk_pix) disable iff (rst)
        (sx < display_pkg::h_total) && (sy < display_pkg::v_total));

endmodule

/* bram_sdp.sv */
/* framebuffer ram
   simple dual-port block ram, one write port and one registered read port */
module bram_sdp (
    input  logic             clk_pix,
    input  logic             we,
    input  fb_pkg::fb_addr_t addr_write,
    input  fb_pkg::fb_colr_t data_in,
    input  fb_pkg::fb_addr_t addr_read,
    output fb_pkg::fb_colr_t data_out
);

    fb_pkg::fb_colr_t mem [0:fb_pkg::fb_pixels-1];

    // image starts out black
    initial begin
        for (int i = 0; i < int'(fb_pkg::fb_pixels); i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, one cycle latency
    // same-address write in the same cycle reads the old value
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

endmodule

/* fb_writer.sv */
/* framebuffer host writer
   four-phase req/ack write port with bounds check and address calculation */
module fb_writer (
    input  logic                clk_pix,
    input  logic                rst,
    input  logic                wr_req,
    input  display_pkg::coord_t wr_x,
    input  display_pkg::coord_t wr_y,
    input  fb_pkg::fb_colr_t    wr_colr,
    output logic                wr_ack,
    output logic                we,
    output fb_pkg::fb_addr_t    addr_write,
    output fb_pkg::fb_colr_t    data_in
);

    typedef enum logic [1:0] {
        idle,          // waiting for wr_req
        ack,           // request taken, write pulse this cycle
        wait_release   // holding ack until wr_req drops
    } state_t;

    state_t state;
    logic in_bounds;          // request lands inside the image
    fb_pkg::fb_addr_t addr;   // y * width + x

    assign in_bounds = (fb_pkg::fb_addr_t'(wr_x) < fb_pkg::fb_width) &&
                       (fb_pkg::fb_addr_t'(wr_y) < fb_pkg::fb_height);
    assign addr = fb_pkg::fb_addr_t'(wr_y) * fb_pkg::fb_width + fb_pkg::fb_addr_t'(wr_x);

    assign wr_ack = (state != idle);  // ack held for the whole transfer

    // handshake fsm and write strobe
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= idle;
            we    <= 1'b0;
        end else begin
            we <= 1'b0;  // single-cycle pulse
            case (state)
                idle: begin
                    if (wr_req) begin
                        state <= ack;
                        we    <= in_bounds;  // out of bounds is acked, not written
                    end
                end
                ack: begin
                    // host may already have dropped req
                    state <= wr_req ? wait_release : idle;
                end
                wait_release: begin
                    if (!wr_req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // latch payload with the request
    always_ff @(posedge clk_pix) begin
        if (state == idle && wr_req) begin
            addr_write <= addr;
            data_in    <= wr_colr;
        end
    end

    // write strobe only together with a fresh ack
    assert property (@(posedge clk_pix) disable iff (rst)
        we |-> !$past(wr_ack));

    // ack only ever answers a request
    assert property (@(posedge clk_pix) disable iff (rst)
        $rose(wr_ack) |-> $past(wr_req));

endmodule

/* fb_scanout.sv */
/* framebuffer scanout
   read address sequencing, sync delay and colour output aligned to ram latency */
module fb_scanout (
    input  logic             clk_pix,
    input  logic             rst,
    display_if.dst           disp,
    output fb_pkg::fb_addr_t addr_read,
    input  fb_pkg::fb_colr_t data_out,
    output logic             vga_hsync,
    output logic             vga_vsync,
    output fb_pkg::rgb_t     vga_r,
    output fb_pkg::rgb_t     vga_g,
    output fb_pkg::rgb_t     vga_b
);

    logic fb_active;  // position inside the 160x120 image
    logic active_d1;  // stage 1 matches ram read data
    logic hsync_d1;
    logic vsync_d1;
    fb_pkg::rgb_t colr;

    assign fb_active = disp.de &&
                       (fb_pkg::fb_addr_t'(disp.sx) < fb_pkg::fb_width) &&
                       (fb_pkg::fb_addr_t'(disp.sy) < fb_pkg::fb_height);

    // address walks the image in raster order
    always_ff @(posedge clk_pix) begin
        if (rst || disp.frame_end) begin
            addr_read <= '0;  // restart at top-left
        end else if (fb_active) begin
            addr_read <= addr_read + 1'b1;
        end
    end

    // stage 1 while ram reads
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            active_d1 <= 1'b0;
            hsync_d1  <= ~display_pkg::sync_active;
            vsync_d1  <= ~display_pkg::sync_active;
        end else begin
            active_d1 <= fb_active;
            hsync_d1  <= disp.hsync;
            vsync_d1  <= disp.vsync;
        end
    end

    assign colr = (active_d1 && data_out) ? fb_pkg::rgb_on : fb_pkg::rgb_off;

    // stage 2 output registers
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= ~display_pkg::sync_active;  // idle high
            vga_vsync <= ~display_pkg::sync_active;
            vga_r     <= fb_pkg::rgb_off;
            vga_g     <= fb_pkg::rgb_off;
            vga_b     <= fb_pkg::rgb_off;
        end else begin
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
            vga_r     <= colr;  // all channels equal
            vga_g     <= colr;
            vga_b     <= colr;
        end
    end

    // black outside the image and through blanking
    // outputs show the raster position from two clocks back
    assert property (@(posedge clk_pix) disable iff (rst)
        ((fb_pkg::fb_addr_t'($past(disp.sx, 2)) >= fb_pkg::fb_width) ||
         (fb_pkg::fb_addr_t'($past(disp.sy, 2)) >= fb_pkg::fb_height)) |->
        (vga_r == fb_pkg::rgb_off && vga_g == fb_pkg::rgb_off &&
         vga_b == fb_pkg::rgb_off));

endmodule

/* fb_display_top.sv */
/* framebuffer display top
   vga timing, 160x120 1-bit framebuffer, host write port and scanout */
module fb_display_top (
    input  logic                clk_pix,
    input  logic                rst,
    input  logic                wr_req,   // host write request
    input  display_pkg::coord_t wr_x,
    input  display_pkg::coord_t wr_y,
    input  fb_pkg::fb_colr_t    wr_colr,
    output logic                wr_ack,   // host write acknowledge
    output logic                vga_hsync,
    output logic                vga_vsync,
    output fb_pkg::rgb_t        vga_r,
    output fb_pkg::rgb_t        vga_g,
    output fb_pkg::rgb_t        vga_b
);

    display_if disp ();  // raster bus

    logic             we;
    fb_pkg::fb_addr_t addr_write;
    fb_pkg::fb_colr_t data_in;
    fb_pkg::fb_addr_t addr_read;
    fb_pkg::fb_colr_t data_out;

    display_timings i_display_timings (
        .clk_pix,
        .rst,
        .disp (disp.src)
    );

    bram_sdp i_framebuffer (
        .clk_pix,
        .we,
        .addr_write,
        .data_in,
        .addr_read,
        .data_out
    );

    fb_writer i_fb_writer (
        .clk_pix,
        .rst,
        .wr_req,
        .wr_x,
        .wr_y,
        .wr_colr,
        .wr_ack,
        .we,
        .addr_write,
        .data_in
    );

    fb_scanout i_fb_scanout (
        .clk_pix,
        .rst,
        .disp (disp.dst),
        .addr_read,
        .data_out,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

endmodule

/* tb_fb_display.sv */
/* framebuffer display testbench
   random host writes mirrored into a shadow image, raster and colour checks over three frames */
module tb_fb_display;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int seed         = 45;
    localparam int n_writes     = 300;
    localparam int x_span       = 200;  // reaches past the 160 wide image
    localparam int y_span       = 150;  // reaches past the 120 high image
    localparam int clk_ns       = 4;
    localparam int reset_cycles = 8;
    localparam int ack_limit    = 16;   // falling edges allowed per handshake phase

    // raster sizes from the timing rules
    localparam int line_cycles  = int'(display_pkg::h_total);
    localparam int frame_cycles = line_cycles * int'(display_pkg::v_total);  // 420000
    localparam int end_count    = 3 * frame_cycles + 2;  // last pixel of frame three out
    localparam int watchdog_ns  = (end_count + reset_cycles) * clk_ns * 6 / 5;  // ~6 ms

    // first and last position of each sync window
    localparam int hs_beg = int'(display_pkg::h_res) + int'(display_pkg::h_fp);
    localparam int hs_end = hs_beg + int'(display_pkg::h_sync) - 1;
    localparam int vs_beg = int'(display_pkg::v_res) + int'(display_pkg::v_fp);
    localparam int vs_end = vs_beg + int'(display_pkg::v_sync) - 1;
    localparam int img_w  = int'(fb_pkg::fb_width);
    localparam int img_h  = int'(fb_pkg::fb_height);

    logic                clk_pix;
    logic                rst;
    logic                wr_req;
    display_pkg::coord_t wr_x;
    display_pkg::coord_t wr_y;
    fb_pkg::fb_colr_t    wr_colr;
    logic                wr_ack;
    logic                vga_hsync;
    logic                vga_vsync;
    fb_pkg::rgb_t        vga_r;
    fb_pkg::rgb_t        vga_g;
    fb_pkg::rgb_t        vga_b;

    bit shadow [0:img_w*img_h-1];  // expected image starting black
    int n = 0;                     // clocks since reset release
    bit rst_seen = 1'b0;           // outputs hold reset values from here on
    int out_lin;                   // linear position now on the outputs
    int ox;
    int oy;
    int frame_idx;
    int idx;                       // shadow index for (ox, oy)
    logic out_valid;
    logic in_image;

    fb_display_top i_fb_display_top (
        .clk_pix,
        .rst,
        .wr_req,
        .wr_x,
        .wr_y,
        .wr_colr,
        .wr_ack,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

    initial clk_pix = 1'b0;
    always #(clk_ns / 2) clk_pix = ~clk_pix;

    always @(posedge clk_pix) begin
        if (rst) begin
            n        <= 0;
            rst_seen <= 1'b1;
        end else begin
            n <= n + 1;
        end
    end

    // outputs lag the raster by two clocks
    always_comb begin
        out_valid = !rst && (n >= 2);
        out_lin   = out_valid ? n - 2 : 0;
        ox        = out_lin % line_cycles;
        oy        = (out_lin / line_cycles) % int'(display_pkg::v_total);
        frame_idx = out_lin / frame_cycles;  // 0 is the first frame
        in_image  = (ox < img_w) && (oy < img_h);
        idx       = in_image ? oy * img_w + ox : 0;
    end

    task automatic fail_check(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    // bounded poll of wr_ack on falling edges
    task automatic wait_ack(input logic level);
        int i;
        i = 0;
        while (wr_ack !== level) begin
            if (i == ack_limit) begin
                $display("handshake timeout, wr_ack never went to %0b", level);
                $display("Done: errors found");
                $fatal(1, "handshake stuck");
            end else begin
                @(negedge clk_pix);
                i++;
            end
        end
    endtask

    // one full four-phase write mirrored into the shadow when in bounds
    task automatic host_write(input display_pkg::coord_t x, input display_pkg::coord_t y,
                              input fb_pkg::fb_colr_t c);
        @(negedge clk_pix);
        wr_x    = x;
        wr_y    = y;
        wr_colr = c;
        wr_req  = 1'b1;
        wait_ack(1'b1);
        wr_req = 1'b0;   // release on the edge that saw ack
        wait_ack(1'b0);  // next request only after ack drops
        if (int'(x) < img_w && int'(y) < img_h) begin
            shadow[int'(y) * img_w + int'(x)] = c;
        end
    endtask

    // idle outputs through reset and the clock after it
    assert property (@(posedge clk_pix) (rst_seen && (rst || n < 2)) |->
        (vga_hsync && vga_vsync && vga_r == 4'd0 && vga_g == 4'd0 && vga_b == 4'd0 && !wr_ack))
        else fail_check("outputs not idle around reset");

    assert property (@(posedge clk_pix) out_valid |->
        (vga_hsync == !(ox >= hs_beg && ox <= hs_end)))
        else fail_check($sformatf("vga_hsync wrong at x %0d y %0d",
                                  $sampled(ox), $sampled(oy)));

    assert property (@(posedge clk_pix) out_valid |->
        (vga_vsync == !(oy >= vs_beg && oy <= vs_end)))
        else fail_check($sformatf("vga_vsync wrong at x %0d y %0d",
                                  $sampled(ox), $sampled(oy)));

    // black outside the image and in blanking
    assert property (@(posedge clk_pix) (out_valid && !in_image) |-> (vga_r == 4'd0))
        else fail_check($sformatf("colour outside image at x %0d y %0d",
                                  $sampled(ox), $sampled(oy)));

    // image matches the shadow once writes are done
    assert property (@(posedge clk_pix)
        (out_valid && in_image && (frame_idx == 1 || frame_idx == 2)) |->
        (vga_r == (shadow[idx] ? fb_pkg::rgb_on : fb_pkg::rgb_off)))
        else fail_check($sformatf("pixel x %0d y %0d frame %0d, got %0h",
                                  $sampled(ox), $sampled(oy),
                                  $sampled(frame_idx) + 1, $sampled(vga_r)));

    assert property (@(posedge clk_pix) rst_seen |-> (vga_r == vga_g && vga_g == vga_b))
        else fail_check("vga_r, vga_g and vga_b differ");

    // four-phase handshake timing
    assert property (@(posedge clk_pix) disable iff (rst) (wr_req && !wr_ack) |=> wr_ack)
        else fail_check("wr_ack did not rise one clock after wr_req");

    assert property (@(posedge clk_pix) disable iff (rst) (!wr_req && wr_ack) |=> !wr_ack)
        else fail_check("wr_ack did not fall one clock after wr_req dropped");

    assert property (@(posedge clk_pix) disable iff (rst) (!wr_req && $past(!wr_req)) |-> !wr_ack)
        else fail_check("wr_ack high with wr_req low for two clocks");

    assert property (@(posedge clk_pix) disable iff (rst) $rose(wr_ack) |-> $past(wr_req))
        else fail_check("wr_ack rose without wr_req");

    initial begin
        rst     = 1'b1;
        wr_req  = 1'b0;
        wr_x    = '0;
        wr_y    = '0;
        wr_colr = 1'b0;
        void'($urandom(seed));
        repeat (reset_cycles) @(posedge clk_pix);
        @(negedge clk_pix);
        rst = 1'b0;
        // writes all land early in frame one
        for (int k = 0; k < n_writes; k++) begin
            host_write(display_pkg::coord_t'($urandom_range(x_span - 1, 0)),
                       display_pkg::coord_t'($urandom_range(y_span - 1, 0)),
                       fb_pkg::fb_colr_t'($urandom_range(1, 0)));
        end
        while (n < end_count) begin
            @(negedge clk_pix);  // frames two and three checked as they pass
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog timeout, run did not reach the end of frame three");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

/* fb_display.f */
display_pkg.sv
fb_pkg.sv
display_if.sv
display_timings.sv
bram_sdp.sv
fb_writer.sv
fb_scanout.sv
fb_display_top.sv
tb_fb_display.sv

/* run.sh */
#!/bin/sh
# compile and run the framebuffer display testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fb_display \
    -f fb_display.f \
    -o sim_fb_display

./obj_dir/sim_fb_display
